// File: src/dcache_params.svh
`ifndef DCACHE_PARAMS_SVH
`define DCACHE_PARAMS_SVH

`define DC_XLEN        32
`define DC_BLOCK_BITS  64
`define DC_OFFSET_BITS 3   // byte within a block
`define DC_INDEX_BITS  5   // 32 lines
`define DC_TAG_BITS    (`DC_XLEN - `DC_INDEX_BITS - `DC_OFFSET_BITS)

// memory transaction tag, zero is no transaction
`define MEM_TAG_BITS   4

`endif

// File: src/cache_pkg.sv
`default_nettype none

`include "dcache_params.svh"

package cache_pkg;

    typedef enum logic [1:0] {
        size_byte = 2'd0,
        size_half = 2'd1,
        size_word = 2'd2
    } access_size_t;

    typedef enum logic {
        op_load  = 1'b0,
        op_store = 1'b1
    } mem_op_t;

    typedef logic [`DC_INDEX_BITS-1:0] line_index_t;
    typedef logic [`DC_TAG_BITS-1:0]   line_tag_t;

    // one block, seen at the granularity of the access
    typedef union packed {
        logic [`DC_BLOCK_BITS/8-1:0][7:0]   bytes;
        logic [`DC_BLOCK_BITS/16-1:0][15:0] halves;
        logic [`DC_BLOCK_BITS/32-1:0][31:0] words;
    } cache_block_t;

    typedef struct packed {
        logic         valid;
        logic         dirty;
        line_tag_t    tag;
        cache_block_t block;
    } cache_line_t;

endpackage

`default_nettype wire

// File: src/mem_bus_pkg.sv
`default_nettype none

`include "dcache_params.svh"

package mem_bus_pkg;

    typedef enum logic [1:0] {
        bus_none  = 2'd0,
        bus_load  = 2'd1,
        bus_store = 2'd2
    } bus_cmd_t;

    // nonzero tags name an accepted transaction
    typedef logic [`MEM_TAG_BITS-1:0] mem_tag_t;

endpackage

`default_nettype wire

// File: src/cache_miss_if.sv
`timescale 1ns/1ps
`default_nettype none

`include "dcache_params.svh"

interface cache_miss_if import cache_pkg::*; ();

    logic                start;        // one cycle, other ctrl fields sampled here
    logic                victim_dirty;
    logic [`DC_XLEN-1:0] victim_addr;
    cache_block_t        victim_block;
    logic [`DC_XLEN-1:0] fetch_addr;

    logic                fill_valid;   // block arrived, or flush write-back accepted
    cache_block_t        fill_block;

    modport ctrl (
        output start, victim_dirty, victim_addr, victim_block, fetch_addr,
        input  fill_valid, fill_block
    );

    modport engine (
        input  start, victim_dirty, victim_addr, victim_block, fetch_addr,
        output fill_valid, fill_block
    );

endinterface

`default_nettype wire

// File: src/cache_store.sv
`timescale 1ns/1ps
`default_nettype none

`include "dcache_params.svh"

module cache_store import cache_pkg::*; (
    input  logic                clock,
    input  logic                reset,
    input  logic [`DC_XLEN-1:0] lookup_addr,
    input  logic                write_en,
    input  access_size_t        write_size,
    input  logic [`DC_XLEN-1:0] write_data,
    input  logic                fill_en,
    input  cache_block_t        fill_block,
    input  logic                clean_en,
    input  line_index_t         scan_index,
    output logic                hit,
    output cache_block_t        hit_block,
    output cache_line_t         victim_line,
    output cache_line_t         scan_line
);

    logic [(1 << `DC_INDEX_BITS)-1:0] valid_bits;
    logic [(1 << `DC_INDEX_BITS)-1:0] dirty_bits;
    line_tag_t    tags   [0:(1 << `DC_INDEX_BITS)-1];
    cache_block_t blocks [0:(1 << `DC_INDEX_BITS)-1];

    line_index_t                 idx;
    line_tag_t                   tag;
    logic [`DC_OFFSET_BITS-1:0]  off;
    cache_block_t                merged;

    function automatic cache_line_t read_line(input line_index_t i);
        cache_line_t line;
        line.valid = valid_bits[i];
        line.dirty = dirty_bits[i];
        line.tag   = tags[i];
        line.block = blocks[i];
        return line;
    endfunction

    assign idx = lookup_addr[`DC_OFFSET_BITS +: `DC_INDEX_BITS];
    assign tag = lookup_addr[`DC_OFFSET_BITS + `DC_INDEX_BITS +: `DC_TAG_BITS];
    assign off = lookup_addr[`DC_OFFSET_BITS-1:0];

    assign hit       = valid_bits[idx] && (tags[idx] == tag);
    assign hit_block = blocks[idx];

    always_comb begin
        victim_line = read_line(idx);   // whatever sits at the index now
        scan_line   = read_line(scan_index);
    end

    // store data lands on top of the incoming block when both happen
    always_comb begin
        merged = fill_en ? fill_block : blocks[idx];
        if (write_en) begin
            case (write_size)
                size_byte: merged.bytes[off] = write_data[7:0];
                size_half: merged.halves[off[`DC_OFFSET_BITS-1:1]] = write_data[15:0];
                default:   merged.words[off[`DC_OFFSET_BITS-1:2]] = write_data;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (fill_en || write_en) begin
            blocks[idx] <= merged;
        end
        if (fill_en) begin
            tags[idx] <= tag;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            valid_bits <= '0;
            dirty_bits <= '0;
        end else begin
            if (fill_en) begin
                valid_bits[idx] <= 1'b1;
                dirty_bits[idx] <= write_en;   // write-allocate store
            end else if (write_en) begin
                dirty_bits[idx] <= 1'b1;
            end
            if (clean_en) begin
                dirty_bits[scan_index] <= 1'b0;   // flushed line now matches memory
            end
        end
    end

    // fills belong to misses, cleans to the flush walk
    fill_clean_exclusive: assert property (
        @(posedge clock) disable iff (reset) !(fill_en && clean_en)
    );

endmodule

`default_nettype wire

// File: src/dcache_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "dcache_params.svh"

module dcache_ctrl import cache_pkg::*; (
    input  logic                clock,
    input  logic                reset,
    input  logic                req_valid,
    input  mem_op_t             req_op,
    input  access_size_t        req_size,
    input  logic [`DC_XLEN-1:0] req_addr,
    input  logic [`DC_XLEN-1:0] req_wdata,
    input  logic                done,
    input  logic                hit,
    input  cache_block_t        hit_block,
    input  cache_line_t         victim_line,
    input  cache_line_t         scan_line,
    output logic                stall,
    output logic                resp_valid,
    output logic [`DC_XLEN-1:0] resp_data,
    output logic                flush_finished,
    output logic [`DC_XLEN-1:0] lookup_addr,
    output logic                write_en,
    output access_size_t        write_size,
    output logic [`DC_XLEN-1:0] write_data,
    output logic                fill_en,
    output cache_block_t        fill_block,
    output logic                clean_en,
    output line_index_t         scan_index,
    cache_miss_if.ctrl          miss
);

    typedef enum logic [2:0] {
        ready, miss_wait, flush_scan, flush_wait, flushed
    } ctrl_state_t;

    ctrl_state_t         state;
    ctrl_state_t         next_state;
    mem_op_t             pend_op;
    access_size_t        pend_size;
    logic [`DC_XLEN-1:0] pend_addr;
    logic [`DC_XLEN-1:0] pend_wdata;

    logic                in_ready;
    logic                req_miss;
    logic                scan_dirty;
    logic                scan_last;
    logic                scan_advance;
    logic                resp_valid_next;
    logic [`DC_XLEN-1:0] resp_data_next;

    // zero-extended load value from one block
    function automatic logic [`DC_XLEN-1:0] load_extract(
        input cache_block_t               blk,
        input access_size_t               size,
        input logic [`DC_OFFSET_BITS-1:0] off
    );
        logic [`DC_XLEN-1:0] value;
        value = '0;
        case (size)
            size_byte: value[7:0]  = blk.bytes[off];
            size_half: value[15:0] = blk.halves[off[`DC_OFFSET_BITS-1:1]];
            default:   value       = blk.words[off[`DC_OFFSET_BITS-1:2]];
        endcase
        return value;
    endfunction

    assign in_ready       = (state == ready);
    assign req_miss       = in_ready && req_valid && !hit;
    assign scan_dirty     = scan_line.valid && scan_line.dirty;
    assign scan_last      = (scan_index == '1);
    assign stall          = !in_ready;
    assign flush_finished = (state == flushed);

    // the pending request owns the store port while its miss is out
    assign lookup_addr = in_ready ? req_addr : pend_addr;
    assign write_size  = in_ready ? req_size : pend_size;
    assign write_data  = in_ready ? req_wdata : pend_wdata;
    assign fill_en     = (state == miss_wait) && miss.fill_valid;
    assign fill_block  = miss.fill_block;
    assign write_en    = (in_ready && req_valid && hit && req_op == op_store)
                      || (fill_en && pend_op == op_store);
    assign clean_en    = (state == flush_wait) && miss.fill_valid;

    assign resp_valid_next = (in_ready && req_valid && hit) || fill_en;
    assign resp_data_next  = load_extract(in_ready ? hit_block : miss.fill_block,
                                          write_size, lookup_addr[`DC_OFFSET_BITS-1:0]);

    assign scan_advance = ((state == flush_scan && !scan_dirty) || clean_en) && !scan_last;

    always_comb begin
        miss.start        = req_miss;
        miss.victim_dirty = victim_line.valid && victim_line.dirty;
        miss.victim_addr  = {victim_line.tag, lookup_addr[`DC_OFFSET_BITS +: `DC_INDEX_BITS],
                             {`DC_OFFSET_BITS{1'b0}}};
        miss.victim_block = victim_line.block;
        miss.fetch_addr   = {lookup_addr[`DC_XLEN-1:`DC_OFFSET_BITS], {`DC_OFFSET_BITS{1'b0}}};
        if (state == flush_scan) begin
            miss.start        = scan_dirty;
            miss.victim_dirty = 1'b1;
            miss.victim_addr  = {scan_line.tag, scan_index, {`DC_OFFSET_BITS{1'b0}}};
            miss.victim_block = scan_line.block;
            miss.fetch_addr   = miss.victim_addr;   // same block, engine does write-back only
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            ready: begin
                if (req_miss) begin
                    next_state = miss_wait;
                end else if (done && !req_valid) begin
                    next_state = flush_scan;
                end
            end
            miss_wait:  if (miss.fill_valid) next_state = ready;
            flush_scan: begin
                if (scan_dirty) begin
                    next_state = flush_wait;
                end else if (scan_last) begin
                    next_state = flushed;
                end
            end
            flush_wait: if (miss.fill_valid) next_state = scan_last ? flushed : flush_scan;
            flushed:    next_state = flushed;   // held until reset
            default:    next_state = ready;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state      <= ready;
            scan_index <= '0;
            resp_valid <= 1'b0;
        end else begin
            state      <= next_state;
            resp_valid <= resp_valid_next;
            if (scan_advance) begin
                scan_index <= scan_index + 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        resp_data <= resp_data_next;
        if (in_ready && req_valid) begin
            pend_op    <= req_op;
            pend_size  <= req_size;
            pend_addr  <= req_addr;
            pend_wdata <= req_wdata;
        end
    end

    no_resp_in_flush: assert property (
        @(posedge clock) disable iff (reset)
        state inside {flush_scan, flush_wait, flushed} |-> !resp_valid
    );

endmodule

`default_nettype wire

// File: src/miss_engine.sv
`timescale 1ns/1ps
`default_nettype none

`include "dcache_params.svh"

module miss_engine import cache_pkg::*, mem_bus_pkg::*; (
    input  logic                      clock,
    input  logic                      reset,
    input  mem_tag_t                  mem_response,
    input  mem_tag_t                  mem_tag,
    input  logic [`DC_BLOCK_BITS-1:0] mem_rdata,
    output bus_cmd_t                  mem_command,
    output logic [`DC_XLEN-1:0]       mem_addr,
    output logic [`DC_BLOCK_BITS-1:0] mem_wdata,
    cache_miss_if.engine              eng
);

    typedef enum logic [1:0] {
        idle, write_back, fetch_issue, fetch_wait
    } engine_state_t;

    engine_state_t       state;
    logic [`DC_XLEN-1:0] wb_addr;
    cache_block_t        wb_block;
    logic [`DC_XLEN-1:0] fetch_addr_q;
    logic                wb_only;    // victim is the requested block, nothing to fetch
    mem_tag_t            load_tag;
    logic                accepted;
    logic                load_back;

    assign accepted  = (mem_response != '0);
    assign load_back = (state == fetch_wait) && (mem_tag == load_tag);

    always_comb begin
        case (state)
            write_back:  mem_command = bus_store;
            fetch_issue: mem_command = bus_load;
            default:     mem_command = bus_none;
        endcase
    end

    assign mem_addr  = (state == write_back) ? wb_addr : fetch_addr_q;
    assign mem_wdata = wb_block;

    assign eng.fill_valid = load_back || (state == write_back && accepted && wb_only);
    assign eng.fill_block = mem_rdata;

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= idle;
        end else begin
            case (state)
                idle: begin
                    if (eng.start) begin
                        state <= eng.victim_dirty ? write_back : fetch_issue;
                    end
                end
                write_back: begin
                    if (accepted) begin   // a store is done once taken
                        state <= wb_only ? idle : fetch_issue;
                    end
                end
                fetch_issue: if (accepted) state <= fetch_wait;
                fetch_wait:  if (load_back) state <= idle;
                default:     state <= idle;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (state == idle && eng.start) begin
            wb_addr      <= eng.victim_addr;
            wb_block     <= eng.victim_block;
            fetch_addr_q <= eng.fetch_addr;
            wb_only      <= eng.victim_dirty
                         && (eng.victim_addr[`DC_XLEN-1:`DC_OFFSET_BITS]
                             == eng.fetch_addr[`DC_XLEN-1:`DC_OFFSET_BITS]);
        end
        if (state == fetch_issue && accepted) begin
            load_tag <= mem_response;   // matched against mem_tag later
        end
    end

    // a refused command must be presented again unchanged
    cmd_held_under_backpressure: assert property (
        @(posedge clock) disable iff (reset)
        (mem_command != bus_none && mem_response == '0)
            |=> $stable(mem_command) && $stable(mem_addr) && $stable(mem_wdata)
    );

endmodule

`default_nettype wire

// File: src/dcache.sv
`timescale 1ns/1ps
`default_nettype none

`include "dcache_params.svh"

module dcache import cache_pkg::*, mem_bus_pkg::*; (
    input  logic                      clock,
    input  logic                      reset,
    input  logic                      req_valid,
    input  mem_op_t                   req_op,
    input  access_size_t              req_size,
    input  logic [`DC_XLEN-1:0]       req_addr,
    input  logic [`DC_XLEN-1:0]       req_wdata,
    output logic                      stall,
    output logic                      resp_valid,
    output logic [`DC_XLEN-1:0]       resp_data,
    output bus_cmd_t                  mem_command,
    output logic [`DC_XLEN-1:0]       mem_addr,
    output logic [`DC_BLOCK_BITS-1:0] mem_wdata,
    input  mem_tag_t                  mem_response,
    input  mem_tag_t                  mem_tag,
    input  logic [`DC_BLOCK_BITS-1:0] mem_rdata,
    input  logic                      done,
    output logic                      flush_finished
);

    logic [`DC_XLEN-1:0] lookup_addr;
    logic                write_en;
    access_size_t        write_size;
    logic [`DC_XLEN-1:0] write_data;
    logic                fill_en;
    cache_block_t        fill_block;
    logic                clean_en;
    line_index_t         scan_index;
    logic                hit;
    cache_block_t        hit_block;
    cache_line_t         victim_line;
    cache_line_t         scan_line;

    cache_miss_if miss_bus ();

    cache_store store (
        .clock       (clock),
        .reset       (reset),
        .lookup_addr (lookup_addr),
        .write_en    (write_en),
        .write_size  (write_size),
        .write_data  (write_data),
        .fill_en     (fill_en),
        .fill_block  (fill_block),
        .clean_en    (clean_en),
        .scan_index  (scan_index),
        .hit         (hit),
        .hit_block   (hit_block),
        .victim_line (victim_line),
        .scan_line   (scan_line)
    );

    dcache_ctrl ctrl (
        .clock          (clock),
        .reset          (reset),
        .req_valid      (req_valid),
        .req_op         (req_op),
        .req_size       (req_size),
        .req_addr       (req_addr),
        .req_wdata      (req_wdata),
        .done           (done),
        .hit            (hit),
        .hit_block      (hit_block),
        .victim_line    (victim_line),
        .scan_line      (scan_line),
        .stall          (stall),
        .resp_valid     (resp_valid),
        .resp_data      (resp_data),
        .flush_finished (flush_finished),
        .lookup_addr    (lookup_addr),
        .write_en       (write_en),
        .write_size     (write_size),
        .write_data     (write_data),
        .fill_en        (fill_en),
        .fill_block     (fill_block),
        .clean_en       (clean_en),
        .scan_index     (scan_index),
        .miss           (miss_bus)
    );

    miss_engine engine (
        .clock        (clock),
        .reset        (reset),
        .mem_response (mem_response),
        .mem_tag      (mem_tag),
        .mem_rdata    (mem_rdata),
        .mem_command  (mem_command),
        .mem_addr     (mem_addr),
        .mem_wdata    (mem_wdata),
        .eng          (miss_bus)
    );

endmodule

`default_nettype wire

// File: testbench/dcache_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "dcache_params.svh"

module dcache_tb import cache_pkg::*, mem_bus_pkg::*; ();

    localparam int MEM_BYTES     = 4096;
    localparam int MISS_TIMEOUT  = 200;
    localparam int FLUSH_TIMEOUT = 4000;

    logic                      clock;
    logic                      reset;
    logic                      req_valid;
    mem_op_t                   req_op;
    access_size_t              req_size;
    logic [`DC_XLEN-1:0]       req_addr;
    logic [`DC_XLEN-1:0]       req_wdata;
    logic                      stall;
    logic                      resp_valid;
    logic [`DC_XLEN-1:0]       resp_data;
    bus_cmd_t                  mem_command;
    logic [`DC_XLEN-1:0]       mem_addr;
    logic [`DC_BLOCK_BITS-1:0] mem_wdata;
    mem_tag_t                  mem_response;
    mem_tag_t                  mem_tag;
    logic [`DC_BLOCK_BITS-1:0] mem_rdata;
    logic                      done;
    logic                      flush_finished;

    logic [7:0]  mem_bytes [0:MEM_BYTES-1];
    logic [7:0]  ref_bytes [0:MEM_BYTES-1];   // memory as it must look after the flush
    logic [31:0] lfsr_state;
    mem_tag_t    next_tag;
    logic        load_pending;
    mem_tag_t    load_tag;
    logic [31:0] load_addr;
    int          load_delay;
    logic [1:0]  accept_pick;

    logic        res_valid [0:31];   // which block each line should hold
    logic [28:0] res_block [0:31];

    int           fd;
    int           field_count;
    logic [1023:0] line_buf;
    logic [63:0]  op_name;
    int           size_bytes;
    logic [31:0]  addr;
    logic [31:0]  wdata;
    logic [31:0]  expect_data;

    dcache uut (
        .clock          (clock),
        .reset          (reset),
        .req_valid      (req_valid),
        .req_op         (req_op),
        .req_size       (req_size),
        .req_addr       (req_addr),
        .req_wdata      (req_wdata),
        .stall          (stall),
        .resp_valid     (resp_valid),
        .resp_data      (resp_data),
        .mem_command    (mem_command),
        .mem_addr       (mem_addr),
        .mem_wdata      (mem_wdata),
        .mem_response   (mem_response),
        .mem_tag        (mem_tag),
        .mem_rdata      (mem_rdata),
        .done           (done),
        .flush_finished (flush_finished)
    );

    always #2 clock = ~clock;

    function automatic logic [7:0] initial_byte(input logic [31:0] a);
        return a[7:0] ^ a[15:8];
    endfunction

    // fibonacci lfsr, taps 32 22 2 1
    function automatic logic random_bit();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function automatic logic [3:0] random_bits(input int count);
        logic [3:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            value = {value[2:0], random_bit()};
        end
        return value;
    endfunction

    function automatic logic [63:0] read_block(input logic [31:0] a);
        logic [63:0] block;
        for (int i = 0; i < 8; i++) begin
            block[8*i +: 8] = mem_bytes[(a + i) % MEM_BYTES];   // little endian
        end
        return block;
    endfunction

    // memory model, decides on the falling edge what the bus shows next
    always @(negedge clock) begin
        mem_response = '0;
        mem_tag      = '0;
        if (reset) begin
            next_tag     = 1;
            load_pending = 1'b0;
        end else begin
            if (load_pending) begin
                load_delay = load_delay - 1;
                if (load_delay == 0) begin
                    mem_tag      = load_tag;
                    mem_rdata    = read_block(load_addr);
                    load_pending = 1'b0;
                end
            end
            if (mem_command != bus_none) begin
                accept_pick = random_bits(2);
                if (accept_pick != 2'b00) begin   // refused one time in four
                    mem_response = next_tag;
                    if (mem_command == bus_store) begin
                        for (int i = 0; i < 8; i++) begin
                            mem_bytes[(mem_addr + i) % MEM_BYTES] = mem_wdata[8*i +: 8];
                        end
                    end else begin
                        load_pending = 1'b1;
                        load_tag     = next_tag;
                        load_addr    = mem_addr;
                        load_delay   = 2 + random_bits(3);   // 2 to 9 cycles
                    end
                    next_tag = (next_tag == '1) ? 1 : next_tag + 1'b1;
                end
            end
        end
    end

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        if (actual !== expected) begin
            fail_run($sformatf("Mismatch at time %0t: %s is %0h, expected %0h",
                               $time, name, actual, expected));
        end
    endtask

    task automatic wait_not_stalled();
        int cycles;
        cycles = 0;
        while (stall && cycles < MISS_TIMEOUT) begin
            @(negedge clock);
            cycles++;
        end
        if (stall) fail_run("timed out waiting for stall to drop");
    endtask

    task automatic wait_response();
        int cycles;
        cycles = 0;
        while (!resp_valid && cycles < MISS_TIMEOUT) begin
            check_value("stall", stall, 1'b1);   // held for the whole miss
            @(negedge clock);
            cycles++;
        end
        if (!resp_valid) fail_run("timed out waiting for a miss response");
    endtask

    task automatic run_access(input logic is_store, input int nbytes, input logic [31:0] a,
                              input logic [31:0] wd, input logic [31:0] expected);
        logic expect_hit;
        expect_hit = res_valid[a[7:3]] && (res_block[a[7:3]] == a[31:3]);
        wait_not_stalled();
        req_valid = 1'b1;
        req_op    = is_store ? op_store : op_load;
        req_size  = (nbytes == 1) ? size_byte : (nbytes == 2) ? size_half : size_word;
        req_addr  = a;
        req_wdata = wd;
        @(negedge clock);
        req_valid = 1'b0;
        check_value("resp_valid", resp_valid, expect_hit);
        if (!expect_hit) wait_response();
        check_value("stall", stall, 1'b0);
        if (is_store) begin
            for (int i = 0; i < nbytes; i++) begin
                ref_bytes[(a + i) % MEM_BYTES] = wd[8*i +: 8];
            end
        end else begin
            check_value("resp_data", resp_data, expected);
        end
        res_valid[a[7:3]] = 1'b1;   // write-allocate, so stores install too
        res_block[a[7:3]] = a[31:3];
    endtask

    task automatic run_flush();
        int cycles;
        wait_not_stalled();
        done = 1'b1;
        @(negedge clock);
        check_value("stall", stall, 1'b1);
        cycles = 0;
        while (!flush_finished && cycles < FLUSH_TIMEOUT) begin
            @(negedge clock);
            cycles++;
        end
        if (!flush_finished) fail_run("timed out waiting for flush_finished");
        for (int a = 0; a < MEM_BYTES; a++) begin
            check_value($sformatf("memory byte %0h", a), mem_bytes[a], ref_bytes[a]);
        end
    endtask

    initial begin
        clock        = 1'b0;
        reset        = 1'b1;
        req_valid    = 1'b0;
        req_op       = op_load;
        req_size     = size_word;
        req_addr     = '0;
        req_wdata    = '0;
        done         = 1'b0;
        mem_response = '0;
        mem_tag      = '0;
        mem_rdata    = '0;
        lfsr_state   = 32'hc64d;
        next_tag     = 1;
        load_pending = 1'b0;
        load_tag     = '0;
        load_addr    = '0;
        load_delay   = 0;
        for (int a = 0; a < MEM_BYTES; a++) begin
            mem_bytes[a] = initial_byte(a);
            ref_bytes[a] = initial_byte(a);
        end
        for (int i = 0; i < 32; i++) begin
            res_valid[i] = 1'b0;
            res_block[i] = '0;
        end
        fd = $fopen("testbench/dcache_stim.txt", "r");
        if (fd == 0) fail_run("cannot open testbench/dcache_stim.txt");
        repeat (8) @(negedge clock);
        reset = 1'b0;

        while (!$feof(fd)) begin
            line_buf = '0;
            op_name  = '0;
            if ($fgets(line_buf, fd) > 0) begin
                field_count = $sscanf(line_buf, "%s %d %h %h %h",
                                      op_name, size_bytes, addr, wdata, expect_data);
                if (field_count > 0 && op_name != "#") begin   // skip blanks and comments
                    if (field_count != 5) begin
                        fail_run("malformed line in stimulus file");
                    end else if (op_name == "load" || op_name == "store") begin
                        run_access(op_name == "store", size_bytes, addr, wdata, expect_data);
                    end else if (op_name == "done") begin
                        run_flush();
                    end else begin
                        fail_run("unknown operation in stimulus file");
                    end
                end
            end
        end
        $fclose(fd);
        $display("all tests passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+src
src/cache_pkg.sv
src/mem_bus_pkg.sv
src/cache_miss_if.sv
src/cache_store.sv
src/dcache_ctrl.sv
src/miss_engine.sv
src/dcache.sv
testbench/dcache_tb.sv

// File: testbench/dcache_stim.txt
# op size(bytes) addr wdata expected_load_data, all hex but size
# initial memory byte at address a is a[7:0] ^ a[15:8]
load  4 00000010 00000000 13121110
load  4 00000010 00000000 13121110
load  1 00000013 00000000 00000013
load  2 00000016 00000000 00001716
load  1 00000125 00000000 00000024
load  2 00000232 00000000 00003130
load  4 000003a4 00000000 a4a5a6a7
store 1 00000011 000000ab 00000000
load  4 00000010 00000000 1312ab10
store 2 00000126 0000beef 00000000
load  4 00000124 00000000 beef2425
store 4 00000048 cafef00d 00000000
load  2 0000004a 00000000 0000cafe
load  1 0000004c 00000000 0000004c
load  4 00000148 00000000 4a4b4849
load  4 00000048 00000000 cafef00d
store 1 00000237 0000005a 00000000
load  1 00000337 00000000 00000034
load  4 00000234 00000000 5a343736
store 2 000002a2 00001234 00000000
load  4 000002a0 00000000 1234a3a2
load  4 000003a4 00000000 a4a5a6a7
store 4 000000f8 89abcdef 00000000
store 1 000001fd 00000077 00000000
load  2 000000fa 00000000 000089ab
store 1 000000ff 0000003c 00000000
load  1 000000ff 00000000 0000003c
done  0 00000000 00000000 00000000
